//--- common/datapath_pkg.sv
package datapath_pkg;

    // widths of the rv64 datapath
    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_COUNT  = 32;
    localparam int REG_IDX_W  = 5;
    localparam int MEM_ADDR_W = 6;  // word address into i/d memories
    localparam int PC_STEP    = 4;  // bytes per instruction

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [ILEN-1:0]       instr_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [2:0]            funct3_t;
    typedef logic [6:0]            funct7_t;

    // major opcodes, standard rv encodings
    typedef enum logic [6:0] {
        OPC_REG    = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // command from the control unit
    typedef enum logic [3:0] {
        CMD_R = 4'b0000,
        CMD_I = 4'b0001,
        CMD_S = 4'b0010,
        CMD_B = 4'b0011
    } alu_cmd_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0110
    } alu_op_e;

    // zero lands in bit 0, negative bit 1, overflow bit 2
    typedef struct packed {
        logic overflow;
        logic negative;
        logic zero;
    } alu_flags_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_COMMIT,
        ST_DONE
    } step_state_e;

endpackage

//--- common/decode_if.sv
interface decode_if;
    import datapath_pkg::*;

    reg_idx_t rs1;     // first source
    reg_idx_t rs2;     // second source, also store data
    reg_idx_t rd;      // write-back target
    xlen_t    imm;     // already sign-extended
    funct3_t  funct3;
    funct7_t  funct7;

    // decoder side
    modport producer (
        output rs1, rs2, rd, imm, funct3, funct7
    );

    // register file and execute unit
    modport consumer (
        input rs1, rs2, rd, imm, funct3, funct7
    );

endinterface

//--- rtl/instr_decoder.sv
module instr_decoder (
    input  datapath_pkg::instr_t  instr,
    output datapath_pkg::opcode_e opcode,
    decode_if.producer            dec
);
    import datapath_pkg::*;

    assign opcode = opcode_e'(instr[6:0]);

    // field positions are the same for every format we keep
    assign dec.rs1    = instr[19:15];
    assign dec.rs2    = instr[24:20];
    assign dec.rd     = instr[11:7];
    assign dec.funct3 = instr[14:12];
    assign dec.funct7 = instr[31:25];

    // immediate per format, sign bit is always instr[31]
    always_comb begin
        case (opcode)
            OPC_LOAD, OPC_OP_IMM: begin
                dec.imm = {{(XLEN-12){instr[31]}}, instr[31:20]};
            end
            OPC_STORE: begin
                dec.imm = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            end
            OPC_BRANCH: begin
                // b-type scrambles bits, offset is even
                dec.imm = {{(XLEN-13){instr[31]}}, instr[31], instr[7],
                           instr[30:25], instr[11:8], 1'b0};
            end
            default: begin
                dec.imm = '0;  // r-type or unknown
            end
        endcase
    end

endmodule

//--- rtl/step_sequencer.sv
module step_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic req,
    input  logic rf_we,
    input  logic d_mem_we,
    output logic ack,
    output logic ir_load,
    output logic pc_load,
    output logic rf_write,
    output logic d_mem_write
);
    import datapath_pkg::*;

    step_state_e state;

    // one req/ack handshake walks idle -> fetch -> commit -> done
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            ack   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) state <= ST_FETCH;
                end
                ST_FETCH: state <= ST_COMMIT;  // ir captured on this edge
                ST_COMMIT: begin
                    state <= ST_DONE;
                    ack   <= 1'b1;  // instruction committed
                end
                ST_DONE: begin
                    // hold ack until the control unit lets go
                    if (!req) begin
                        state <= ST_IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // strobes decoded from state, only commit writes anything
    assign ir_load     = (state == ST_FETCH);
    assign pc_load     = (state == ST_COMMIT);
    assign rf_write    = (state == ST_COMMIT) && rf_we;
    assign d_mem_write = (state == ST_COMMIT) && d_mem_we;

endmodule

//--- rtl/fetch_unit.sv
module fetch_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ir_load,
    input  logic                   pc_load,
    input  logic                   pc_src,     // branch instruction
    input  datapath_pkg::instr_t   i_mem_data,
    input  datapath_pkg::xlen_t    imm,
    input  logic                   zero,       // rs1 == rs2 from the alu
    output datapath_pkg::instr_t   instr,
    output datapath_pkg::mem_addr_t i_mem_addr
);
    import datapath_pkg::*;

    xlen_t  pc;
    xlen_t  next_pc;
    instr_t ir;

    // beq only: taken when control says branch and operands match
    always_comb begin
        if (pc_src && zero)
            next_pc = pc + imm;
        else
            next_pc = pc + xlen_t'(PC_STEP);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;  // boot from address 0
            ir <= '0;
        end else begin
            if (pc_load) pc <= next_pc;      // commit edge
            if (ir_load) ir <= i_mem_data;   // fetch edge
        end
    end

    assign instr      = ir;
    assign i_mem_addr = pc[MEM_ADDR_W+1:2];  // word index, byte offset dropped

endmodule

//--- register_file/register_file.sv
module register_file (
    input  logic                clk,
    input  logic                reset,
    input  logic                rf_write,
    input  datapath_pkg::xlen_t wdata,
    output datapath_pkg::xlen_t rs1_data,
    output datapath_pkg::xlen_t rs2_data,
    decode_if.consumer          dec
);
    import datapath_pkg::*;

    xlen_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_write && dec.rd != '0) begin
            regs[dec.rd] <= wdata;  // x0 never written
        end
    end

    // combinational reads, x0 forced to zero
    assign rs1_data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2_data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

endmodule

//--- execute/execute_unit.sv
module execute_unit (
    input  datapath_pkg::xlen_t      rs1_data,
    input  datapath_pkg::xlen_t      rs2_data,
    input  logic                     alu_src,   // 1 picks the immediate
    input  datapath_pkg::alu_cmd_e   alu_cmd,
    output datapath_pkg::xlen_t      result,
    output datapath_pkg::alu_flags_t flags,
    decode_if.consumer               dec
);
    import datapath_pkg::*;

    alu_op_e alu_op;
    xlen_t   operand_b;
    logic    sign_a;
    logic    sign_b;
    logic    sign_r;

    // only r-type sub subtracts, loads/stores/branches add
    always_comb begin
        alu_op = ALU_ADD;
        if (alu_cmd == CMD_R && dec.funct7 == 7'b0100000 && dec.funct3 == 3'b000)
            alu_op = ALU_SUB;
    end

    assign operand_b = alu_src ? dec.imm : rs2_data;

    assign result = (alu_op == ALU_SUB) ? rs1_data - operand_b
                                        : rs1_data + operand_b;

    assign sign_a = rs1_data[XLEN-1];
    assign sign_b = operand_b[XLEN-1];
    assign sign_r = result[XLEN-1];

    assign flags.zero     = (rs1_data == operand_b);  // beq compare
    assign flags.negative = sign_r;
    // add overflows on same signs, sub on different signs
    assign flags.overflow = (alu_op == ALU_SUB) ? (sign_a != sign_b) && (sign_r != sign_a)
                                                : (sign_a == sign_b) && (sign_r != sign_a);

endmodule

//--- rtl/riscv_datapath.sv
module riscv_datapath (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req,
    input  logic                     rf_we,
    input  logic                     d_mem_we,
    input  logic                     pc_src,
    input  logic                     rf_src,     // 1 writes back memory data
    input  logic                     alu_src,
    input  datapath_pkg::alu_cmd_e   alu_cmd,
    input  datapath_pkg::instr_t     i_mem_data,
    input  datapath_pkg::xlen_t      d_mem_rdata,
    output logic                     ack,
    output datapath_pkg::opcode_e    opcode,     // to the control unit
    output datapath_pkg::mem_addr_t  i_mem_addr,
    output datapath_pkg::mem_addr_t  d_mem_addr,
    output datapath_pkg::xlen_t      d_mem_wdata,
    output logic                     d_mem_write,
    output datapath_pkg::alu_flags_t alu_flags
);
    import datapath_pkg::*;

    logic   ir_load;
    logic   pc_load;
    logic   rf_write;
    instr_t instr;
    xlen_t  rs1_data;
    xlen_t  rs2_data;
    xlen_t  alu_result;
    xlen_t  wb_data;

    decode_if dec_bus ();

    step_sequencer u_seq (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .rf_we       (rf_we),
        .d_mem_we    (d_mem_we),
        .ack         (ack),
        .ir_load     (ir_load),
        .pc_load     (pc_load),
        .rf_write    (rf_write),
        .d_mem_write (d_mem_write)
    );

    fetch_unit u_fetch (
        .clk        (clk),
        .reset      (reset),
        .ir_load    (ir_load),
        .pc_load    (pc_load),
        .pc_src     (pc_src),
        .i_mem_data (i_mem_data),
        .imm        (dec_bus.imm),
        .zero       (alu_flags.zero),  // branch condition
        .instr      (instr),
        .i_mem_addr (i_mem_addr)
    );

    instr_decoder u_dec (
        .instr  (instr),
        .opcode (opcode),
        .dec    (dec_bus.producer)
    );

    register_file u_rf (
        .clk      (clk),
        .reset    (reset),
        .rf_write (rf_write),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dec      (dec_bus.consumer)
    );

    execute_unit u_exe (
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .alu_src  (alu_src),
        .alu_cmd  (alu_cmd),
        .result   (alu_result),
        .flags    (alu_flags),
        .dec      (dec_bus.consumer)
    );

    // write-back select, load data or alu result
    assign wb_data = rf_src ? d_mem_rdata : alu_result;

    assign d_mem_addr  = alu_result[MEM_ADDR_W-1:0];  // effective address, low bits
    assign d_mem_wdata = rs2_data;                    // store data

endmodule

//--- dv/riscv_datapath_properties.sv
module riscv_datapath_properties (
    input logic                      clk,
    input logic                      reset,
    input logic                      req,
    input logic                      ack,
    input logic                      d_mem_write,
    input datapath_pkg::step_state_e state
);
    import datapath_pkg::*;

    int assert_fails = 0;  // read by the testbench at the end

    // ack is registered, so it is low one edge into reset
    ack_low_in_reset: assert property (@(posedge clk) reset |=> !ack)
        else begin assert_fails++; $error("ack high during reset"); end

    strobe_one_cycle: assert property (@(posedge clk) disable iff (reset)
        d_mem_write |=> !d_mem_write)
        else begin assert_fails++; $error("d_mem_write longer than one cycle"); end

    no_strobe_with_ack: assert property (@(posedge clk) disable iff (reset)
        !(d_mem_write && ack))
        else begin assert_fails++; $error("d_mem_write while ack high"); end

    // back-pressure in done, ack held while req stays up
    ack_held_until_req_low: assert property (@(posedge clk) disable iff (reset)
        (state == ST_DONE && req) |=> ack)
        else begin assert_fails++; $error("ack dropped before req fell"); end

endmodule

bind step_sequencer riscv_datapath_properties u_props (
    .clk(clk), .reset(reset), .req(req), .ack(ack), .d_mem_write(d_mem_write), .state(state)
);

//--- dv/riscv_datapath_tb.sv
module riscv_datapath_tb;
    import datapath_pkg::*;

    localparam int NUM_ROWS       = 16;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 8 + RESET_CYCLES + 50;
    localparam xlen_t MAX_POS     = {1'b0, {(XLEN-1){1'b1}}};
    localparam xlen_t MIN_NEG     = {1'b1, {(XLEN-1){1'b0}}};

    // ctrl packs {rf_we, d_mem_we, pc_src, rf_src, alu_src}
    typedef struct packed {
        instr_t     word;
        logic [4:0] ctrl;
        alu_cmd_e   cmd;
        xlen_t      rdata;       // what the data memory returns
        opcode_e    exp_opcode;
        mem_addr_t  exp_addr;
        xlen_t      exp_wdata;
        logic       exp_strobe;
        alu_flags_t exp_flags;
        mem_addr_t  exp_pc;      // i_mem_addr once ack is back low
    } test_row_t;

    logic clk, reset, req, rf_we, d_mem_we, pc_src, rf_src, alu_src, ack, d_mem_write;
    alu_cmd_e   alu_cmd;
    instr_t     i_mem_data;
    xlen_t      d_mem_rdata, d_mem_wdata, seen_wdata;
    opcode_e    opcode;
    mem_addr_t  i_mem_addr, d_mem_addr, seen_addr;
    alu_flags_t alu_flags, seen_flags;
    logic       seen_strobe;
    test_row_t  rows [NUM_ROWS];
    int         error_count = 0;
    int         row_errors;
    int         cycle_count = 0;

    riscv_datapath UUT (.*);

    always #4 clk = ~clk;

    // hang guard, one stuck handshake ends the run
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("handshake never completed, stopped after %0d cycles", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic report_error(input string name, input xlen_t got, input xlen_t exp);
        error_count++;
        row_errors++;
        $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) report_error(name, got, exp);
    endtask

    task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
        if (got !== exp) report_error(name, xlen_t'(got), xlen_t'(exp));
    endtask

    task automatic check_flags(input string name, input alu_flags_t got, input alu_flags_t exp);
        if (got !== exp) report_error(name, xlen_t'(got), xlen_t'(exp));
    endtask

    task automatic check_opcode(input string name, input opcode_e got, input opcode_e exp);
        if (got !== exp) report_error(name, xlen_t'(got), xlen_t'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report_error(name, xlen_t'(got), xlen_t'(exp));
    endtask

    initial begin
        test_row_t r;
        clk = 1'b0;
        reset = 1'b1;
        req = 1'b0;
        {rf_we, d_mem_we, pc_src, rf_src, alu_src} = 5'b0;
        alu_cmd = CMD_R;
        i_mem_data = '0;
        d_mem_rdata = '0;
        // addi x1 = 5, addi x2 = -3, add x3, sub x4
        rows[0]  = '{32'h00500093, 5'b10001, CMD_I, 64'h0,
                     OPC_OP_IMM, 6'd5, 64'h0, 1'b0, 3'b000, 6'd1};
        rows[1]  = '{32'hffd00113, 5'b10001, CMD_I, 64'h0,
                     OPC_OP_IMM, 6'd61, 64'h0, 1'b0, 3'b010, 6'd2};
        rows[2]  = '{32'h002081b3, 5'b10000, CMD_R, 64'h0,
                     OPC_REG, 6'd2, xlen_t'(-3), 1'b0, 3'b000, 6'd3};
        rows[3]  = '{32'h40110233, 5'b10000, CMD_R, 64'h0,
                     OPC_REG, 6'd56, 64'h5, 1'b0, 3'b010, 6'd4};
        // ld x6 = max positive, addi x8 = -1, sub x7 overflows
        rows[4]  = '{32'h00003303, 5'b10011, CMD_I, MAX_POS,
                     OPC_LOAD, 6'd0, 64'h0, 1'b0, 3'b001, 6'd5};
        rows[5]  = '{32'hfff00413, 5'b10001, CMD_I, 64'h0,
                     OPC_OP_IMM, 6'd63, 64'h0, 1'b0, 3'b010, 6'd6};
        rows[6]  = '{32'h408303b3, 5'b10000, CMD_R, 64'h0,
                     OPC_REG, 6'd0, xlen_t'(-1), 1'b0, 3'b110, 6'd7};
        // sw x3,8(x1) with and without the strobe
        rows[7]  = '{32'h0030a423, 5'b01001, CMD_S, 64'h0,
                     OPC_STORE, 6'd13, 64'h2, 1'b1, 3'b000, 6'd8};
        rows[8]  = '{32'h0030a423, 5'b00001, CMD_S, 64'h0,
                     OPC_STORE, 6'd13, 64'h2, 1'b0, 3'b000, 6'd9};
        // ld x5 then store it back, write x0 then store x0
        rows[9]  = '{32'h00403283, 5'b10011, CMD_I, 64'h1234,
                     OPC_LOAD, 6'd4, xlen_t'(-8), 1'b0, 3'b000, 6'd10};
        rows[10] = '{32'h00502023, 5'b01001, CMD_S, 64'h0,
                     OPC_STORE, 6'd0, 64'h1234, 1'b1, 3'b001, 6'd11};
        rows[11] = '{32'h00700013, 5'b10001, CMD_I, 64'h0,
                     OPC_OP_IMM, 6'd7, MIN_NEG, 1'b0, 3'b000, 6'd12};
        rows[12] = '{32'h00002023, 5'b01001, CMD_S, 64'h0,
                     OPC_STORE, 6'd0, 64'h0, 1'b1, 3'b001, 6'd13};
        // beq +8 taken, not taken, and taken but pc_src clear
        rows[13] = '{32'h00108463, 5'b00100, CMD_B, 64'h0,
                     OPC_BRANCH, 6'd10, 64'h5, 1'b0, 3'b001, 6'd15};
        rows[14] = '{32'h00208463, 5'b00100, CMD_B, 64'h0,
                     OPC_BRANCH, 6'd2, xlen_t'(-3), 1'b0, 3'b000, 6'd16};
        rows[15] = '{32'h00108463, 5'b00000, CMD_B, 64'h0,
                     OPC_BRANCH, 6'd10, 64'h5, 1'b0, 3'b001, 6'd17};
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            r = rows[i];
            row_errors = 0;
            seen_strobe = 1'b0;
            @(posedge clk);
            #1;
            i_mem_data  = r.word;  // instruction memory answer
            {rf_we, d_mem_we, pc_src, rf_src, alu_src} = r.ctrl;
            alu_cmd     = r.cmd;
            d_mem_rdata = r.rdata;
            req         = 1'b1;
            // last sample before ack rises is the commit cycle
            while (!ack) begin
                @(negedge clk);
                if (!ack) begin
                    seen_addr   = d_mem_addr;
                    seen_wdata  = d_mem_wdata;
                    seen_flags  = alu_flags;
                    seen_strobe = seen_strobe | d_mem_write;
                end
            end
            @(posedge clk);
            #1 req = 1'b0;
            while (ack) @(negedge clk);  // four-phase return to idle
            check_word("d_mem_wdata", seen_wdata, r.exp_wdata);
            check_addr("d_mem_addr", seen_addr, r.exp_addr);
            check_bit("d_mem_write", seen_strobe, r.exp_strobe);
            check_flags("alu_flags", seen_flags, r.exp_flags);
            check_addr("i_mem_addr", i_mem_addr, r.exp_pc);
            check_opcode("opcode", opcode, r.exp_opcode);
            $display("row %0d instr %h %s", i, r.word, (row_errors == 0) ? "ok" : "FAILED");
        end
        error_count += UUT.u_seq.u_props.assert_fails;
        $display("rows %0d, errors %0d", NUM_ROWS, error_count);
        if (error_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- riscv_datapath.f
common/datapath_pkg.sv
common/decode_if.sv
rtl/instr_decoder.sv
rtl/step_sequencer.sv
rtl/fetch_unit.sv
register_file/register_file.sv
execute/execute_unit.sv
rtl/riscv_datapath.sv
dv/riscv_datapath_properties.sv
dv/riscv_datapath_tb.sv

//--- Bender.yml
package:
  name: riscv_datapath

sources:
  - common/datapath_pkg.sv
  - common/decode_if.sv
  - rtl/instr_decoder.sv
  - rtl/step_sequencer.sv
  - rtl/fetch_unit.sv
  - register_file/register_file.sv
  - execute/execute_unit.sv
  - rtl/riscv_datapath.sv
  - target: dv
    files:
      - dv/riscv_datapath_properties.sv
      - dv/riscv_datapath_tb.sv
